/* keyboard_params.svh */
`ifndef KEYBOARD_PARAMS_SVH
`define KEYBOARD_PARAMS_SVH

// BBC key matrix geometry
`define NUM_COLUMNS 16
`define NUM_ROWS 8

// PS/2 scan code values
`define BREAK_CODE 8'hF0 // key release prefix

// column value of a key code with no place in the matrix
`define UNMAPPED_COLUMN 4'hF

// start, eight data, parity and stop
`define FRAME_BITS 11

`endif

/* ps2Pkg.sv */
`default_nettype none

package ps2Pkg;

	// one byte as received from the keyboard
	typedef logic [7:0] scanCode_t;

	// receiver frame position
	typedef enum logic [1:0] {
		rxIdle, // waiting for start bit
		rxData, // shifting in the byte
		rxParity,
		rxStop
	} rxState_t;

endpackage

`default_nettype wire

/* bbcKeyPkg.sv */
`default_nettype none

`include "keyboard_params.svh"

package bbcKeyPkg;

	typedef logic [$clog2(`NUM_COLUMNS)-1:0] columnIdx_t;
	typedef logic [$clog2(`NUM_ROWS)-1:0] rowIdx_t;

	// row in the upper bits, column in the lower bits
	typedef logic [$bits(rowIdx_t)+$bits(columnIdx_t)-1:0] keyCode_t;

	// bit n of one matrix column is row n
	typedef logic [`NUM_ROWS-1:0] rowBits_t;

endpackage

`default_nettype wire

/* keyEventIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface keyEventIf;

	logic keyStrobe; // one enabled cycle per event
	logic keyRelease; // 1 = release, 0 = press
	bbcKeyPkg::columnIdx_t keyColumn;
	bbcKeyPkg::rowIdx_t keyRow;

	modport sender (
		output keyStrobe,
		output keyRelease,
		output keyColumn,
		output keyRow
	);

	modport column (
		input keyStrobe,
		input keyRelease,
		input keyColumn,
		input keyRow
	);

endinterface

`default_nettype wire

/* ps2Receiver.sv */
`timescale 1ns/1ps
`default_nettype none

`include "keyboard_params.svh"

module ps2Receiver (
	input logic clk,
	input logic clkEn,
	input logic nRESET,
	input logic ps2Clk,
	input logic ps2Data,
	output logic done,
	output ps2Pkg::scanCode_t data
);

	localparam int DATA_BITS = `FRAME_BITS - 3; // minus start, parity, stop
	localparam int COUNT_W = $clog2(DATA_BITS);

	logic [1:0] clkSync;
	logic [1:0] dataSync;
	logic clkLast;
	logic fallEdge;
	logic parityAcc;
	logic doneLast;
	logic [COUNT_W-1:0] bitCount;
	ps2Pkg::rxState_t state;
	ps2Pkg::scanCode_t shiftReg;

	assign fallEdge = clkLast & ~clkSync[1]; // keyboard drives data while clock is high

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			clkSync <= 2'b11; // idle bus is high
			dataSync <= 2'b11;
			clkLast <= 1'b1;
			state <= ps2Pkg::rxIdle;
			bitCount <= '0;
			parityAcc <= 1'b0;
			done <= 1'b0;
			doneLast <= 1'b0;
		end else if (clkEn) begin
			clkSync <= {clkSync[0], ps2Clk};
			dataSync <= {dataSync[0], ps2Data};
			clkLast <= clkSync[1];
			doneLast <= done;
			done <= 1'b0;
			if (fallEdge) begin
				case (state)
					ps2Pkg::rxIdle: begin
						bitCount <= '0;
						parityAcc <= 1'b0;
						if (!dataSync[1]) begin // start bit must be 0
							state <= ps2Pkg::rxData;
						end
					end
					ps2Pkg::rxData: begin
						parityAcc <= parityAcc ^ dataSync[1];
						bitCount <= bitCount + 1'b1;
						if (bitCount == COUNT_W'(DATA_BITS - 1)) begin
							state <= ps2Pkg::rxParity;
						end
					end
					ps2Pkg::rxParity: begin
						parityAcc <= parityAcc ^ dataSync[1]; // odd over nine bits
						state <= ps2Pkg::rxStop;
					end
					default: begin
						done <= parityAcc & dataSync[1]; // bad frames vanish here
						state <= ps2Pkg::rxIdle;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clkEn && fallEdge && state == ps2Pkg::rxData) begin
			shiftReg <= {dataSync[1], shiftReg[$bits(shiftReg)-1:1]}; // lsb first
		end
		if (clkEn && fallEdge && state == ps2Pkg::rxStop) begin
			data <= shiftReg;
		end
	end

	doneSinglePulse: assert property (@(posedge clk) disable iff (!nRESET)
		clkEn |-> !(done && doneLast))
		else $error("ps2Receiver: done high on two enabled cycles in a row");

endmodule

`default_nettype wire

/* scanTranslator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "keyboard_params.svh"

module scanTranslator (
	input logic clk,
	input logic clkEn,
	input logic nRESET,
	input logic done,
	input ps2Pkg::scanCode_t data,
	keyEventIf.sender events
);

	bbcKeyPkg::keyCode_t bbcCode;
	logic mapped;
	logic releasePending;

	always_comb begin
		case (data)
			8'h76: bbcCode = 7'h70; // escape
			8'h16: bbcCode = 7'h30;
			8'h1E: bbcCode = 7'h31;
			8'h26: bbcCode = 7'h11;
			8'h25: bbcCode = 7'h12;
			8'h2E: bbcCode = 7'h13;
			8'h36: bbcCode = 7'h34;
			8'h3D: bbcCode = 7'h24;
			8'h3E: bbcCode = 7'h15;
			8'h46: bbcCode = 7'h26;
			8'h45: bbcCode = 7'h27;
			8'h4E: bbcCode = 7'h17; // minus
			8'h66: bbcCode = 7'h59; // backspace as delete
			8'h0D: bbcCode = 7'h60; // tab
			8'h15: bbcCode = 7'h10;
			8'h1D: bbcCode = 7'h21;
			8'h24: bbcCode = 7'h22;
			8'h2D: bbcCode = 7'h33;
			8'h2C: bbcCode = 7'h23;
			8'h35: bbcCode = 7'h44;
			8'h3C: bbcCode = 7'h35;
			8'h43: bbcCode = 7'h25;
			8'h44: bbcCode = 7'h36;
			8'h4D: bbcCode = 7'h37;
			8'h54: bbcCode = 7'h38; // open bracket
			8'h5B: bbcCode = 7'h58; // close bracket
			8'h5A: bbcCode = 7'h49; // return
			8'h14: bbcCode = 7'h01; // left ctrl
			8'h1C: bbcCode = 7'h41;
			8'h1B: bbcCode = 7'h51;
			8'h23: bbcCode = 7'h32;
			8'h2B: bbcCode = 7'h43;
			8'h34: bbcCode = 7'h53;
			8'h33: bbcCode = 7'h54;
			8'h3B: bbcCode = 7'h45;
			8'h42: bbcCode = 7'h46;
			8'h4B: bbcCode = 7'h56;
			8'h4C: bbcCode = 7'h57; // semicolon
			8'h52: bbcCode = 7'h28; // quote as underscore
			8'h0E: bbcCode = 7'h18; // backtick as caret
			8'h12: bbcCode = 7'h00; // left shift
			8'h61: bbcCode = 7'h78; // uk backslash
			8'h1A: bbcCode = 7'h61;
			8'h22: bbcCode = 7'h42;
			8'h21: bbcCode = 7'h52;
			8'h2A: bbcCode = 7'h63;
			8'h32: bbcCode = 7'h64;
			8'h31: bbcCode = 7'h55;
			8'h3A: bbcCode = 7'h65;
			8'h41: bbcCode = 7'h66; // comma
			8'h49: bbcCode = 7'h67; // full stop
			8'h4A: bbcCode = 7'h68; // slash
			8'h59: bbcCode = 7'h00; // right shift, same key as left
			8'h11: bbcCode = 7'h50; // left alt as shift lock
			8'h29: bbcCode = 7'h62; // space
			8'h58: bbcCode = 7'h40; // caps lock
			8'h05: bbcCode = 7'h71; // f1
			8'h06: bbcCode = 7'h72;
			8'h04: bbcCode = 7'h73;
			8'h0C: bbcCode = 7'h14;
			8'h03: bbcCode = 7'h74;
			8'h0B: bbcCode = 7'h75;
			8'h83: bbcCode = 7'h16;
			8'h0A: bbcCode = 7'h76;
			8'h01: bbcCode = 7'h77;
			8'h09: bbcCode = 7'h20; // f10 as f0
			8'h75: bbcCode = 7'h39; // up
			8'h6B: bbcCode = 7'h19; // left
			8'h74: bbcCode = 7'h79; // right
			8'h72: bbcCode = 7'h29; // down
			8'h55: bbcCode = 7'h48; // equals as colon
			8'h78: bbcCode = 7'h47; // f11 as at
			8'h07: bbcCode = 7'h69; // f12 as copy
			default: bbcCode = {3'd0, `UNMAPPED_COLUMN}; // break and e0 land here too
		endcase
	end

	assign mapped = bbcCode[3:0] != `UNMAPPED_COLUMN;

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			releasePending <= 1'b0;
			events.keyStrobe <= 1'b0;
		end else if (clkEn) begin
			events.keyStrobe <= done & mapped;
			if (done && data == `BREAK_CODE) begin
				releasePending <= 1'b1;
			end else if (done && mapped) begin
				releasePending <= 1'b0; // flag consumed by this key
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clkEn && done && mapped) begin
			events.keyRelease <= releasePending;
			events.keyColumn <= bbcCode[3:0];
			events.keyRow <= bbcCode[6:4];
		end
	end

	noUnmappedEvent: assert property (@(posedge clk) disable iff (!nRESET)
		$rose(events.keyStrobe) |-> events.keyColumn != `UNMAPPED_COLUMN)
		else $error("scanTranslator: key event issued for an unmapped code");

endmodule

`default_nettype wire

/* keyColumn.sv */
`timescale 1ns/1ps
`default_nettype none

`include "keyboard_params.svh"

module keyColumn #(
	parameter int COLUMN_INDEX = 0 // 0 to NUM_COLUMNS-1
) (
	input logic clk,
	input logic clkEn,
	input logic nRESET,
	keyEventIf.column events,
	output bbcKeyPkg::rowBits_t rowBits
);

	logic hit;

	// every column sees every event and picks its own
	assign hit = events.keyStrobe
		&& (events.keyColumn == bbcKeyPkg::columnIdx_t'(COLUMN_INDEX));

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			rowBits <= {`NUM_ROWS{1'b0}};
		end else if (clkEn && hit) begin
			rowBits[events.keyRow] <= ~events.keyRelease; // press sets, release clears
		end
	end

endmodule

`default_nettype wire

/* matrixScanner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "keyboard_params.svh"

module matrixScanner (
	input logic clk,
	input logic clkEn,
	input logic nRESET,
	input logic autoscan,
	input bbcKeyPkg::columnIdx_t column,
	input bbcKeyPkg::rowIdx_t row,
	input bbcKeyPkg::rowBits_t [`NUM_COLUMNS-1:0] matrix,
	output logic columnMatch,
	output logic rowMatch,
	output logic rowDrive
);

	bbcKeyPkg::columnIdx_t scanCount;
	bbcKeyPkg::columnIdx_t selColumn;
	bbcKeyPkg::rowBits_t selBits;

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			scanCount <= '0;
		end else if (clkEn) begin
			if (scanCount == bbcKeyPkg::columnIdx_t'(`NUM_COLUMNS - 1)) begin
				scanCount <= '0;
			end else begin
				scanCount <= scanCount + 1'b1;
			end
		end
	end

	assign selColumn = autoscan ? scanCount : column;
	assign selBits = matrix[selColumn];

	assign columnMatch = |selBits[`NUM_ROWS-1:1]; // row 0 is shift and ctrl
	assign rowMatch = ~autoscan & selBits[row]; // host row only in direct mode
	assign rowDrive = ~autoscan; // enables the external row driver

endmodule

`default_nettype wire

/* bbcKeyboard.sv */
`timescale 1ns/1ps
`default_nettype none

`include "keyboard_params.svh"

module bbcKeyboard (
	input logic clk,
	input logic clkEn,
	input logic nRESET,
	input logic autoscan,
	input logic [3:0] column,
	input logic [2:0] row,
	input logic ps2Clk,
	input logic ps2Data,
	output logic columnMatch,
	output logic rowMatch,
	output logic rowDrive
);

	logic rxDone;
	ps2Pkg::scanCode_t rxData;
	bbcKeyPkg::rowBits_t [`NUM_COLUMNS-1:0] matrix;

	keyEventIf keyEvents ();

	ps2Receiver receiver (
		.clk(clk),
		.clkEn(clkEn),
		.nRESET(nRESET),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.done(rxDone),
		.data(rxData)
	);

	scanTranslator translator (
		.clk(clk),
		.clkEn(clkEn),
		.nRESET(nRESET),
		.done(rxDone),
		.data(rxData),
		.events(keyEvents)
	);

	for (genvar c = 0; c < `NUM_COLUMNS; c++) begin : gColumn
		keyColumn #(
			.COLUMN_INDEX(c)
		) columnBank (
			.clk(clk),
			.clkEn(clkEn),
			.nRESET(nRESET),
			.events(keyEvents),
			.rowBits(matrix[c])
		);
	end

	matrixScanner scanner (
		.clk(clk),
		.clkEn(clkEn),
		.nRESET(nRESET),
		.autoscan(autoscan),
		.column(column),
		.row(row),
		.matrix(matrix),
		.columnMatch(columnMatch),
		.rowMatch(rowMatch),
		.rowDrive(rowDrive)
	);

endmodule

`default_nettype wire

/* tbBbcKeyboard.sv */
`timescale 1ns/1ps
`default_nettype none

`include "keyboard_params.svh"

module tbBbcKeyboard;

	logic clk;
	logic clkEn;
	logic nRESET;
	logic autoscan;
	logic [3:0] column;
	logic [2:0] row;
	logic ps2Clk;
	logic ps2Data;
	logic columnMatch;
	logic rowMatch;
	logic rowDrive;

	int errorCount = 0;
	int timeoutCount = 0;
	int checkCount = 0;
	int seed = 27;
	int order [12];
	int hits;
	int i;
	int j;
	int tmp;
	logic [15:0] entry;

	// each entry is scan code, column, row (one hex digit each for column and row)
	logic [15:0] keyTable [12] = '{
		16'h1200, 16'h5900, 16'h2926, 16'h0517, // shifts, space, f1
		16'h7593, 16'h6B91, 16'h7497, 16'h7292, // arrows
		16'h1C14, 16'h5A94, 16'h7607, 16'h1501
	};

	bbcKeyboard uut (
		.clk(clk),
		.clkEn(clkEn),
		.nRESET(nRESET),
		.autoscan(autoscan),
		.column(column),
		.row(row),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.columnMatch(columnMatch),
		.rowMatch(rowMatch),
		.rowDrive(rowDrive)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			errorCount++;
		end
	endtask

	// start, data lsb first, odd parity, stop
	task automatic sendFrame(input logic [7:0] code, input bit badParity);
		logic [`FRAME_BITS-1:0] frame;
		int b;
		frame = {1'b1, (~^code) ^ badParity, code, 1'b0};
		for (b = 0; b < `FRAME_BITS; b++) begin
			@(posedge clk);
			ps2Data <= frame[b];
			repeat (4) @(posedge clk);
			ps2Clk <= 1'b0; // receiver samples here
			repeat (4) @(posedge clk);
			ps2Clk <= 1'b1;
		end
		@(posedge clk);
		ps2Data <= 1'b1;
	endtask

	task automatic releaseKey(input logic [7:0] code);
		sendFrame(`BREAK_CODE, 1'b0);
		sendFrame(code, 1'b0);
	endtask

	task automatic waitMatch(input bit useColumn, input logic [3:0] col,
		input logic [2:0] r, input logic expected);
		int cycles;
		logic seen;
		@(posedge clk);
		column <= col;
		row <= r;
		cycles = 0;
		seen = ~expected;
		while (seen !== expected && cycles < 200) begin
			@(negedge clk);
			seen = useColumn ? columnMatch : rowMatch;
			cycles++;
		end
		if (seen !== expected) begin
			$display("timeout: %s never became %0d at column %0d row %0d in 200 cycles",
				useColumn ? "columnMatch" : "rowMatch", expected, col, r);
			timeoutCount++;
		end
	endtask

	task automatic checkMatrixEmpty();
		int c;
		int r;
		for (c = 0; c < `NUM_COLUMNS; c++) begin
			for (r = 0; r < `NUM_ROWS; r++) begin
				@(posedge clk);
				column <= c[3:0];
				row <= r[2:0];
				@(negedge clk);
				checkValue($sformatf("rowMatch[%0d][%0d]", c, r), 32'(rowMatch), 0);
				checkValue($sformatf("columnMatch[%0d]", c), 32'(columnMatch), 0);
			end
		end
	endtask

	initial begin
		clkEn = 1'b1;
		nRESET = 1'b0;
		autoscan = 1'b0;
		column = 4'd0;
		row = 3'd0;
		ps2Clk = 1'b1; // idle bus
		ps2Data = 1'b1;
		repeat (2) @(posedge clk);
		nRESET <= 1'b1;

		for (i = 0; i < 12; i++) order[i] = i;
		for (i = 11; i > 0; i--) begin // shuffle table order
			j = $unsigned($random(seed)) % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end

		for (i = 0; i < 12; i++) begin
			entry = keyTable[order[i]];
			sendFrame(entry[15:8], 1'b0);
			waitMatch(1'b0, entry[7:4], entry[2:0], 1'b1);
			@(posedge clk);
			row <= entry[2:0] ^ 3'd1;
			@(negedge clk);
			checkValue("rowMatch other row", 32'(rowMatch), 0);
			releaseKey(entry[15:8]);
			waitMatch(1'b0, entry[7:4], entry[2:0], 1'b0);
			checkMatrixEmpty();
		end

		sendFrame(8'h12, 1'b0); // left shift lives in row 0
		waitMatch(1'b0, 4'd0, 3'd0, 1'b1);
		@(negedge clk);
		checkValue("columnMatch with shift", 32'(columnMatch), 0);
		sendFrame(8'h15, 1'b0);
		waitMatch(1'b1, 4'd0, 3'd1, 1'b1);
		releaseKey(8'h12);
		releaseKey(8'h15);
		waitMatch(1'b0, 4'd0, 3'd1, 1'b0);

		sendFrame(8'h15, 1'b1); // bad parity
		sendFrame(8'h7E, 1'b0); // unmapped
		repeat (200) @(posedge clk);
		checkMatrixEmpty();

		sendFrame(8'h29, 1'b0);
		waitMatch(1'b0, 4'd2, 3'd6, 1'b1);
		@(posedge clk);
		autoscan <= 1'b1;
		hits = 0;
		repeat (`NUM_COLUMNS) begin
			@(negedge clk);
			if (columnMatch) hits++;
			checkValue("rowDrive", 32'(rowDrive), 0);
			checkValue("rowMatch", 32'(rowMatch), 0);
		end
		checkValue("autoscan columnMatch count", hits, 1);
		@(posedge clk);
		autoscan <= 1'b0;
		@(negedge clk);
		checkValue("rowDrive", 32'(rowDrive), 1);

		sendFrame(8'h05, 1'b0); // space still held
		waitMatch(1'b0, 4'd1, 3'd7, 1'b1);
		sendFrame(8'h75, 1'b0);
		waitMatch(1'b0, 4'd9, 3'd3, 1'b1);
		@(posedge clk);
		nRESET <= 1'b0;
		repeat (2) @(posedge clk);
		nRESET <= 1'b1;
		checkMatrixEmpty();

		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
ps2Pkg.sv
bbcKeyPkg.sv
keyEventIf.sv
ps2Receiver.sv
scanTranslator.sv
keyColumn.sv
matrixScanner.sv
bbcKeyboard.sv
tbBbcKeyboard.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --timing --assert
TOP = tbBbcKeyboard
FILELIST = filelist.f
OBJ_DIR = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
